//--- design/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// address and data width of both the hart and the memory port
`define CACHE_ADDR_W 32

// byte offset inside a 16 byte line
`define CACHE_OFFSET_W 4

// set index width, which gives 32 sets
`define CACHE_SET_W 5
`define CACHE_SETS (1 << `CACHE_SET_W)

// tag is whatever is left above the set index
`define CACHE_TAG_W 23

// four 32-bit words per line, addressed by a two bit word index
`define CACHE_WORDS 4
`define CACHE_WORD_W 2

// two ways per set with NMRU replacement
`define CACHE_WAYS 2

`endif

//--- design/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // hart request as seen by the controller

    // one request from the hart, read and write never come together
    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0]   addr;
        logic                       ren;
        logic                       wen;
        // one bit per byte lane of the word
        logic [`CACHE_ADDR_W/8-1:0] mask;
        logic [`CACHE_ADDR_W-1:0]   wdata;
    } req_t;

    ////////////////////////////////////////////////////////////////////////////
    // ports from the controller into the ways

    // a single word write into the selected way
    // used for refill words and for store hits alike
    typedef struct packed {
        logic                      en;
        logic [`CACHE_SET_W-1:0]   set;
        logic [`CACHE_WORD_W-1:0]  word;
        logic [`CACHE_ADDR_W-1:0]  data;
    } way_wr_t;

    // raised together with the last refill word
    // the way then installs the tag at the write set and marks the line valid
    typedef struct packed {
        logic                     en;
        logic [`CACHE_TAG_W-1:0]  tag;
    } fill_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller FSM

    typedef enum logic [2:0] {
        LOOKUP,
        STORE_WAIT,
        FILL_REQ,
        FILL_WAIT,
        STORE_FINISH,
        LOAD_FINISH
    } ctrl_state_e;

endpackage

//--- design/cache_way.sv
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_way (
    input  logic                      i_clk,
    input  logic                      i_rst,
    // lookup side, driven from the live or the captured request
    input  logic [`CACHE_SET_W-1:0]   i_set,
    input  logic [`CACHE_TAG_W-1:0]   i_tag,
    input  logic [`CACHE_WORD_W-1:0]  i_word,
    // the write side is only taken when this way is selected
    input  cache_pkg::way_wr_t        i_wr,
    input  cache_pkg::fill_t          i_fill,
    input  logic                      i_sel,
    // lookup result
    output logic                      o_hit,
    output logic [`CACHE_ADDR_W-1:0]  o_rdata
);

    // each set holds one tag, one valid bit and four data words
    logic [`CACHE_TAG_W-1:0]  tags  [`CACHE_SETS];
    logic [`CACHE_ADDR_W-1:0] datas [`CACHE_SETS][`CACHE_WORDS];
    logic [`CACHE_SETS-1:0]   valid;

    ////////////////////////////////////////////////////////////////////////////
    // lookup

    // hit needs both a valid line and a matching tag
    assign o_hit = valid[i_set] && (tags[i_set] == i_tag);

    // the selector only uses this word when the way hits
    assign o_rdata = datas[i_set][i_word];

    ////////////////////////////////////////////////////////////////////////////
    // writes

    // refill words and store hits both write the data array
    always_ff @(posedge i_clk) begin
        if (i_sel && i_wr.en) begin
            datas[i_wr.set][i_wr.word] <= i_wr.data;
        end
    end

    // the tag goes in with the last refill word at the set of that write
    always_ff @(posedge i_clk) begin
        if (i_sel && i_fill.en) begin
            tags[i_wr.set] <= i_fill.tag;
        end
    end

    // a line only turns valid when its last word has arrived
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid <= '0;
        end else if (i_sel && i_fill.en) begin
            valid[i_wr.set] <= 1'b1;
        end
    end

endmodule

//--- design/cache_way_select.sv
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_way_select (
    input  logic                                      i_clk,
    input  logic                                      i_rst,
    // per way lookup results
    input  logic [`CACHE_WAYS-1:0]                    i_hit,
    input  logic [`CACHE_WAYS-1:0][`CACHE_ADDR_W-1:0] i_rdata,
    // set of the current lookup, also the set the MRU bit is kept for
    input  logic [`CACHE_SET_W-1:0]                   i_set,
    // mark i_touch_way as most recently used in i_set
    input  logic                                      i_touch,
    input  logic                                      i_touch_way,
    output logic                                      o_hit,
    output logic                                      o_hit_way,
    output logic                                      o_victim,
    output logic [`CACHE_ADDR_W-1:0]                  o_res_rdata
);

    // one MRU bit per set, it names the way used last
    logic [`CACHE_SETS-1:0] mru;

    ////////////////////////////////////////////////////////////////////////////
    // hit merge

    // a line lives in at most one way, so the hit way is just way 1's hit
    assign o_hit     = |i_hit;
    assign o_hit_way = i_hit[1];

    // the hart sees this word directly on a load hit
    // and again in the last cycle of a load miss
    assign o_res_rdata = i_rdata[o_hit_way];

    ////////////////////////////////////////////////////////////////////////////
    // NMRU

    // with two ways the victim is simply the way not used last
    assign o_victim = ~mru[i_set];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mru <= '0;
        end else if (i_touch) begin
            mru[i_set] <= i_touch_way;
        end
    end

endmodule

//--- design/cache_ctrl.sv
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    // hart request
    input  cache_pkg::req_t            i_req,
    // combined lookup result from the way selector
    input  logic                       i_hit,
    input  logic                       i_hit_way,
    input  logic                       i_victim,
    input  logic [`CACHE_ADDR_W-1:0]   i_rdata,
    // memory port
    input  logic                       i_mem_ready,
    input  logic                       i_mem_valid,
    input  logic [`CACHE_ADDR_W-1:0]   i_mem_rdata,
    output logic                       o_busy,
    output logic [`CACHE_ADDR_W-1:0]   o_mem_addr,
    output logic                       o_mem_ren,
    output logic                       o_mem_wen,
    output logic [`CACHE_ADDR_W-1:0]   o_mem_wdata,
    // lookup fields into every way
    output logic [`CACHE_SET_W-1:0]    o_set,
    output logic [`CACHE_TAG_W-1:0]    o_tag,
    output logic [`CACHE_WORD_W-1:0]   o_word,
    // write ports and per way enables
    output cache_pkg::way_wr_t         o_wr,
    output cache_pkg::fill_t           o_fill,
    output logic [`CACHE_WAYS-1:0]     o_way_sel,
    // NMRU update
    output logic                       o_touch,
    output logic                       o_touch_way
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e next_state;

    // request held while the hart is stalled, plus the way it targets
    cache_pkg::req_t            cap_req;
    logic                       cap_way;
    logic                       cap_en;
    logic                       cap_way_d;

    // request the lookup currently works on
    cache_pkg::req_t            cur_req;
    logic [`CACHE_WORD_W-1:0]   fill_cnt;
    logic [`CACHE_ADDR_W-1:0]   merged;

    // store data is laid byte by byte over the old word
    // since the memory port has no byte mask
    function automatic logic [`CACHE_ADDR_W-1:0] merge_bytes(
        input logic [`CACHE_ADDR_W-1:0]   old_word,
        input logic [`CACHE_ADDR_W-1:0]   new_word,
        input logic [`CACHE_ADDR_W/8-1:0] mask
    );
        logic [`CACHE_ADDR_W-1:0] result;
        result = old_word;
        for (int b = 0; b < `CACHE_ADDR_W / 8; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // lookup fields

    // only LOOKUP looks at the live request, later states use the copy
    assign cur_req = (state == cache_pkg::LOOKUP) ? i_req : cap_req;
    assign o_set   = cur_req.addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
    assign o_tag   = cur_req.addr[`CACHE_OFFSET_W + `CACHE_SET_W +: `CACHE_TAG_W];
    assign o_word  = cur_req.addr[2 +: `CACHE_WORD_W];

    // i_rdata is the cached word at the request offset whenever the line hits
    assign merged = merge_bytes(i_rdata, cur_req.wdata, cur_req.mask);

    ////////////////////////////////////////////////////////////////////////////
    // state and counters

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= cache_pkg::LOOKUP;
        end else begin
            state <= next_state;
        end
    end

    // refill word counter, it wraps back to zero after the last word
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            fill_cnt <= '0;
        end else if (state == cache_pkg::FILL_WAIT && i_mem_valid) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (cap_en) begin
            cap_req <= i_req;
            cap_way <= cap_way_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM outputs

    always_comb begin
        next_state  = state;
        o_busy      = 1'b0;
        o_mem_addr  = {cur_req.addr[`CACHE_ADDR_W-1:2], 2'b00};
        o_mem_ren   = 1'b0;
        o_mem_wen   = 1'b0;
        o_mem_wdata = merged;
        o_wr        = '0;
        o_wr.set    = o_set;
        o_wr.word   = o_word;
        o_wr.data   = merged;
        o_fill      = '0;
        o_fill.tag  = o_tag;
        o_way_sel   = '0;
        o_touch     = 1'b0;
        o_touch_way = i_hit_way;
        cap_en      = 1'b0;
        cap_way_d   = i_victim;

        case (state)
            cache_pkg::LOOKUP: begin
                if (i_req.ren && i_hit) begin
                    // load hit, data goes out through the selector this cycle
                    o_touch = 1'b1;
                end else if (i_req.wen && i_hit) begin
                    if (i_mem_ready) begin
                        // store hit, write the way and memory together
                        o_mem_wen           = 1'b1;
                        o_wr.en             = 1'b1;
                        o_way_sel[i_hit_way] = 1'b1;
                        o_touch             = 1'b1;
                    end else begin
                        o_busy     = 1'b1;
                        cap_en     = 1'b1;
                        cap_way_d  = i_hit_way;
                        next_state = cache_pkg::STORE_WAIT;
                    end
                end else if (i_req.ren || i_req.wen) begin
                    // any miss allocates the NMRU victim
                    o_busy     = 1'b1;
                    cap_en     = 1'b1;
                    next_state = cache_pkg::FILL_REQ;
                end
            end
            cache_pkg::STORE_WAIT: begin
                o_busy = ~i_mem_ready;
                if (i_mem_ready) begin
                    o_mem_wen           = 1'b1;
                    o_wr.en             = 1'b1;
                    o_way_sel[cap_way]  = 1'b1;
                    o_touch             = 1'b1;
                    o_touch_way         = cap_way;
                    next_state          = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::FILL_REQ: begin
                // one read per word, line base first
                o_busy     = 1'b1;
                o_mem_addr = {cur_req.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], fill_cnt, 2'b00};
                if (i_mem_ready) begin
                    o_mem_ren  = 1'b1;
                    next_state = cache_pkg::FILL_WAIT;
                end
            end
            cache_pkg::FILL_WAIT: begin
                o_busy    = 1'b1;
                o_wr.word = fill_cnt;
                o_wr.data = i_mem_rdata;
                if (i_mem_valid) begin
                    o_wr.en            = 1'b1;
                    o_way_sel[cap_way] = 1'b1;
                    next_state         = cache_pkg::FILL_REQ;
                    if (&fill_cnt) begin
                        // last word installs the tag and makes the line MRU
                        o_fill.en   = 1'b1;
                        o_touch     = 1'b1;
                        o_touch_way = cap_way;
                        next_state  = cap_req.wen ? cache_pkg::STORE_FINISH
                                                  : cache_pkg::LOAD_FINISH;
                    end
                end
            end
            cache_pkg::LOAD_FINISH: begin
                // line now hits, so the selector returns the requested word
                next_state = cache_pkg::LOOKUP;
            end
            cache_pkg::STORE_FINISH: begin
                o_busy = ~i_mem_ready;
                if (i_mem_ready) begin
                    o_mem_wen          = 1'b1;
                    o_wr.en            = 1'b1;
                    o_way_sel[cap_way] = 1'b1;
                    next_state         = cache_pkg::LOOKUP;
                end
            end
            default: begin
                next_state = cache_pkg::LOOKUP;
            end
        endcase
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_top (
    input  logic                      i_clk,
    input  logic                      i_rst,
    // hart side
    input  logic [`CACHE_ADDR_W-1:0]  i_req_addr,
    input  logic                      i_req_ren,
    input  logic                      i_req_wen,
    input  logic [`CACHE_ADDR_W/8-1:0] i_req_mask,
    input  logic [`CACHE_ADDR_W-1:0]  i_req_wdata,
    output logic [`CACHE_ADDR_W-1:0]  o_res_rdata,
    output logic                      o_busy,
    // memory side, word wide and without a byte mask
    input  logic                      i_mem_ready,
    output logic [`CACHE_ADDR_W-1:0]  o_mem_addr,
    output logic                      o_mem_ren,
    output logic                      o_mem_wen,
    output logic [`CACHE_ADDR_W-1:0]  o_mem_wdata,
    input  logic [`CACHE_ADDR_W-1:0]  i_mem_rdata,
    input  logic                      i_mem_valid
);

    cache_pkg::req_t                           req;
    cache_pkg::way_wr_t                        way_wr;
    cache_pkg::fill_t                          fill;
    logic [`CACHE_SET_W-1:0]                   set;
    logic [`CACHE_TAG_W-1:0]                   tag;
    logic [`CACHE_WORD_W-1:0]                  word;
    logic [`CACHE_WAYS-1:0]                    way_sel;
    logic [`CACHE_WAYS-1:0]                    way_hit;
    logic [`CACHE_WAYS-1:0][`CACHE_ADDR_W-1:0] way_rdata;
    logic                                      hit;
    logic                                      hit_way;
    logic                                      victim;
    logic [`CACHE_ADDR_W-1:0]                  rdata;
    logic                                      touch;
    logic                                      touch_way;

    assign req = '{addr: i_req_addr, ren: i_req_ren, wen: i_req_wen,
                   mask: i_req_mask, wdata: i_req_wdata};

    // controller also sees the selected word for the store merge
    assign o_res_rdata = rdata;

    cache_ctrl u_ctrl (
        .i_clk, .i_rst, .i_req(req),
        .i_hit(hit), .i_hit_way(hit_way), .i_victim(victim), .i_rdata(rdata),
        .i_mem_ready, .i_mem_valid, .i_mem_rdata,
        .o_busy, .o_mem_addr, .o_mem_ren, .o_mem_wen, .o_mem_wdata,
        .o_set(set), .o_tag(tag), .o_word(word),
        .o_wr(way_wr), .o_fill(fill), .o_way_sel(way_sel),
        .o_touch(touch), .o_touch_way(touch_way)
    );

    // every way sees the same lookup and write ports, the enable picks one
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_way u_way (
            .i_clk, .i_rst,
            .i_set(set), .i_tag(tag), .i_word(word),
            .i_wr(way_wr), .i_fill(fill), .i_sel(way_sel[w]),
            .o_hit(way_hit[w]), .o_rdata(way_rdata[w])
        );
    end

    cache_way_select u_sel (
        .i_clk, .i_rst,
        .i_hit(way_hit), .i_rdata(way_rdata), .i_set(set),
        .i_touch(touch), .i_touch_way(touch_way),
        .o_hit(hit), .o_hit_way(hit_way), .o_victim(victim), .o_res_rdata(rdata)
    );

endmodule

//--- tb/cache_assertions.sv
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_assertions (
    input logic                     i_clk,
    input logic                     i_rst,
    input logic                     i_mem_ready,
    input logic                     o_busy,
    input logic                     o_mem_ren,
    input logic                     o_mem_wen,
    input logic [`CACHE_ADDR_W-1:0] o_mem_addr
);

    // number of failed assertions that the testbench adds to its counts
    int unsigned fail_count = 0;

    // the memory port carries one transfer per cycle
    assert property (@(posedge i_clk) disable iff (i_rst) !(o_mem_ren && o_mem_wen))
        else begin
            $error("read and write strobes are high in the same cycle");
            fail_count++;
        end

    // the port is word wide so the two low address bits stay zero
    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_mem_ren || o_mem_wen) |-> (o_mem_addr[1:0] == 2'b00))
        else begin
            $error("memory strobe with an address that is not word aligned");
            fail_count++;
        end

    // under back-pressure the cache keeps both strobes low
    assert property (@(posedge i_clk) disable iff (i_rst)
        !i_mem_ready |-> !(o_mem_ren || o_mem_wen))
        else begin
            $error("memory strobe issued while memory was not ready");
            fail_count++;
        end

    // the first cycle out of reset is idle on both sides
    assert property (@(posedge i_clk) $fell(i_rst) |-> !(o_busy || o_mem_ren || o_mem_wen))
        else begin
            $error("busy or a memory strobe is high in the cycle after reset");
            fail_count++;
        end

endmodule

// every cache instance carries the protocol checks
bind cache_top cache_assertions u_assertions (
    .i_clk, .i_rst, .i_mem_ready, .o_busy, .o_mem_ren, .o_mem_wen, .o_mem_addr
);

//--- tb/cache_tb.sv
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_tb;

    // cycles a single access may stay busy before it counts as hung
    localparam int TIMEOUT = 200;

    logic                          i_clk = 1'b0;
    logic                          i_rst;
    logic [`CACHE_ADDR_W-1:0]      i_req_addr;
    logic                          i_req_ren;
    logic                          i_req_wen;
    logic [`CACHE_ADDR_W/8-1:0]    i_req_mask;
    logic [`CACHE_ADDR_W-1:0]      i_req_wdata;
    logic [`CACHE_ADDR_W-1:0]      o_res_rdata;
    logic                          o_busy;
    logic                          i_mem_ready = 1'b0;
    logic [`CACHE_ADDR_W-1:0]      o_mem_addr;
    logic                          o_mem_ren;
    logic                          o_mem_wen;
    logic [`CACHE_ADDR_W-1:0]      o_mem_wdata;
    logic [`CACHE_ADDR_W-1:0]      i_mem_rdata = '0;
    logic                          i_mem_valid = 1'b0;

    // 16 KiB of memory as the DUT writes it and as the hart expects to read it
    logic [`CACHE_ADDR_W-1:0]      mem [4096];
    logic [`CACHE_ADDR_W-1:0]      ref_mem [4096];
    // the one outstanding read and the log of read addresses per access
    logic [`CACHE_ADDR_W-1:0]      rd_addr = '0;
    int                            rd_wait = 0;
    logic [`CACHE_ADDR_W-1:0]      rd_log [$];
    logic                          rand_ready = 1'b0;
    int                            errors = 0;
    int                            timeouts = 0;

    cache_top cache_top_i (.*);

    always #5 i_clk = ~i_clk;

    // a distinct start word for every word address
    function automatic logic [`CACHE_ADDR_W-1:0] init_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    // enabled bytes come from the store and all others from the old word
    function automatic logic [`CACHE_ADDR_W-1:0] byte_merge(input logic [31:0] old_word,
                                                            input logic [31:0] new_word,
                                                            input logic [3:0]  mask);
        logic [31:0] lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (new_word & lanes) | (old_word & ~lanes);
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // memory model

    // transfers are taken at the rising edge where the strobes have settled
    always @(posedge i_clk) begin
        if (!i_rst && i_mem_ready && o_mem_wen) begin
            mem[o_mem_addr[13:2]] = o_mem_wdata;
        end
        if (!i_rst && i_mem_ready && o_mem_ren) begin
            rd_addr = o_mem_addr;
            rd_wait = $urandom_range(4, 1);
            rd_log.push_back(o_mem_addr);
        end
    end

    // ready and read data change on the falling edge like all other inputs
    always @(negedge i_clk) begin
        i_mem_valid = 1'b0;
        i_mem_ready = rand_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
        if (rd_wait == 1) begin
            i_mem_valid = 1'b1;
            i_mem_rdata = mem[rd_addr[13:2]];
        end
        if (rd_wait != 0) begin
            rd_wait--;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // hart side

    // starts on a falling edge and drops the strobes after the first rising edge
    // expect_miss is 1 for a miss, 0 for a hit and -1 where either is fine
    task automatic hart_access(input logic [31:0] addr, input logic write,
                               input logic [3:0] mask, input logic [31:0] wdata,
                               input int expect_miss);
        logic [31:0] exp_word;
        logic        stalled;
        logic        missed;
        int          cycles;
        exp_word    = write ? byte_merge(ref_mem[addr[13:2]], wdata, mask)
                            : ref_mem[addr[13:2]];
        rd_log.delete();
        i_req_addr  = addr;
        i_req_ren   = !write;
        i_req_wen   = write;
        i_req_mask  = mask;
        i_req_wdata = wdata;
        cycles      = 0;
        @(posedge i_clk);
        stalled = o_busy;
        while (o_busy && cycles < TIMEOUT) begin
            @(negedge i_clk);
            i_req_ren = 1'b0;
            i_req_wen = 1'b0;
            @(posedge i_clk);
            cycles++;
        end
        // the cycle with o_busy low carries the load word or the store write
        if (o_busy) begin
            timeouts++;
            $display("access to %h was still busy after %0d cycles", addr, TIMEOUT);
        end else if (write) begin
            check_cond(o_mem_wen, $sformatf("store to %h ended without a memory write", addr));
            check_equal("o_mem_addr", o_mem_addr, {addr[31:2], 2'b00});
            check_equal("o_mem_wdata", o_mem_wdata, exp_word);
        end else begin
            check_equal("o_res_rdata", o_res_rdata, exp_word);
        end
        @(negedge i_clk);
        i_req_ren = 1'b0;
        i_req_wen = 1'b0;
        if (write) begin
            ref_mem[addr[13:2]] = exp_word;
        end
        // a refill reads the whole line in order from word 0
        missed = rd_log.size() != 0;
        if (missed) begin
            check_cond(rd_log.size() == 4,
                       $sformatf("refill for %h issued %0d reads", addr, rd_log.size()));
            foreach (rd_log[i]) begin
                check_equal("o_mem_addr", rd_log[i], {addr[31:4], 4'h0} + 4 * i);
            end
        end
        if (expect_miss >= 0) begin
            check_cond(stalled == (expect_miss == 1) && missed == (expect_miss == 1),
                       $sformatf("access to %h did not %s", addr,
                                 (expect_miss == 1) ? "miss" : "hit"));
        end
    endtask

    initial begin
        void'($urandom(66474));
        i_rst       = 1'b1;
        i_req_addr  = '0;
        i_req_ren   = 1'b0;
        i_req_wen   = 1'b0;
        i_req_mask  = '0;
        i_req_wdata = '0;
        for (int i = 0; i < 4096; i++) begin
            mem[i]     = init_word(i);
            ref_mem[i] = init_word(i);
        end
        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;
        @(posedge i_clk);
        check_cond(!o_busy && !o_mem_ren && !o_mem_wen, "cache not idle after reset");
        @(negedge i_clk);

        // load miss and then hits on the same line
        hart_access(32'h0000_0104, 1'b0, 4'h0, '0, 1);
        hart_access(32'h0000_0100, 1'b0, 4'h0, '0, 0);
        hart_access(32'h0000_010c, 1'b0, 4'h0, '0, 0);
        // store hit on two bytes and the read back
        hart_access(32'h0000_0108, 1'b1, 4'b0101, 32'hdead_beef, 0);
        hart_access(32'h0000_0108, 1'b0, 4'h0, '0, 0);
        // store miss allocates the line before the write goes through
        hart_access(32'h0000_1238, 1'b1, 4'b1100, 32'h1234_5678, 1);
        hart_access(32'h0000_1238, 1'b0, 4'h0, '0, 0);
        // A B and C share set 4 so C has to evict B
        hart_access(32'h0000_0040, 1'b0, 4'h0, '0, 1);
        hart_access(32'h0000_0240, 1'b0, 4'h0, '0, 1);
        hart_access(32'h0000_0040, 1'b0, 4'h0, '0, 0);
        hart_access(32'h0000_0440, 1'b0, 4'h0, '0, 1);
        hart_access(32'h0000_0040, 1'b0, 4'h0, '0, 0);
        hart_access(32'h0000_0240, 1'b0, 4'h0, '0, 1);

        // random traffic over four tags and four sets under back-pressure
        @(posedge i_clk);
        rand_ready = 1'b1;
        @(negedge i_clk);
        repeat (300) begin
            hart_access($urandom & 32'h0000_063c, 1'($urandom_range(1, 0)),
                        4'($urandom_range(15, 1)), $urandom, -1);
        end

        $display("counts: %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, cache_top_i.u_assertions.fail_count);
        if (errors + timeouts + cache_top_i.u_assertions.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/cache_pkg.sv
design/cache_way.sv
design/cache_way_select.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/cache_assertions.sv
tb/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/cache_way.sv
      - design/cache_way_select.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
      - tb/cache_assertions.sv
      - tb/cache_tb.sv
